// File: rtl/collect_cfg_pkg.sv
/* default sizes of the packet collector
   the top level takes its parameter defaults from here and passes them down */
package collect_cfg_pkg;

    // input streams gathered onto the one output
    parameter int NUM_CH = 16;

    // beat width of every stream
    parameter int DATA_W = 32;

    // per-channel count hint, beats still queued
    parameter int CNT_W = 8;

endpackage

// File: rtl/collect_ctrl_pkg.sv
/* control encodings of the packet collector
   arbitration mode and combiner state */
package collect_ctrl_pkg;

    // which seeker the combiner starts
    typedef enum logic {
        ARB_ROUND_ROBIN = 1'b0,
        ARB_MAX_COUNT   = 1'b1
    } arb_mode_e;

    // combiner FSM
    // idle issues a start, seek waits for done or empty,
    // locked holds one channel until its last beat
    typedef enum logic [1:0] {
        MUX_IDLE   = 2'd0,
        MUX_SEEK   = 2'd1,
        MUX_LOCKED = 2'd2
    } mux_state_e;

endpackage

// File: rtl/seek_if.sv
/* request path between the combiner and one channel seeker
   start from the combiner, done or empty plus the channel back from the seeker */
`timescale 1ns/1ps

interface seek_if #(
    parameter int num_ch = collect_cfg_pkg::NUM_CH
);
    localparam int ch_w = (num_ch > 1) ? $clog2(num_ch) : 1;

    // one-cycle pulse, never raised mid-search
    logic start;
    // search found a channel, one-cycle pulse
    logic done;
    // full pass without a valid channel, one-cycle pulse
    logic empty;
    // granted channel, held from done until the next start
    logic [ch_w-1:0] ch;

    modport seeker (
        input  start,
        output done,
        output empty,
        output ch
    );

    modport combiner (
        output start,
        input  done,
        input  empty,
        input  ch
    );

endinterface

// File: rtl/rr_seeker.sv
/* round-robin channel search, one channel examined per cycle
   scan begins at a rotating pointer that moves past each granted channel */
`timescale 1ns/1ps

module rr_seeker #(
    parameter int num_ch = collect_cfg_pkg::NUM_CH
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [num_ch-1:0] valid,
    seek_if.seeker            seek
);
    localparam int ch_w = (num_ch > 1) ? $clog2(num_ch) : 1;
    localparam logic [ch_w-1:0] last_ch = ch_w'(num_ch - 1);

    logic            busy;
    logic [ch_w-1:0] ptr;
    logic [ch_w-1:0] idx;
    logic [ch_w-1:0] lap;
    logic [ch_w-1:0] ch_q;
    logic            done_q;
    logic            empty_q;

    // channel looked at this cycle and how many came before it
    logic [ch_w-1:0] cur;
    logic [ch_w-1:0] seen;
    logic [ch_w-1:0] cur_next;
    logic            hit;

    always_comb begin
        // first channel is examined in the start cycle itself
        cur      = seek.start ? ptr : idx;
        seen     = seek.start ? '0 : lap;
        cur_next = (cur == last_ch) ? '0 : cur + 1'b1;
        hit      = valid[cur];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            ptr     <= '0;
            idx     <= '0;
            lap     <= '0;
            done_q  <= 1'b0;
            empty_q <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            empty_q <= 1'b0;
            if (seek.start || busy) begin
                if (hit) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                    // next search starts just past the winner
                    ptr    <= cur_next;
                end else if (seen == last_ch) begin
                    // whole lap without a valid channel
                    busy    <= 1'b0;
                    empty_q <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    idx  <= cur_next;
                    lap  <= seen + 1'b1;
                end
            end
        end
    end

    // winner index, holds until a later hit
    always_ff @(posedge clk) begin
        if ((seek.start || busy) && hit) begin
            ch_q <= cur;
        end
    end

    assign seek.done  = done_q;
    assign seek.empty = empty_q;
    assign seek.ch    = ch_q;

endmodule

// File: rtl/max_count_seeker.sv
/* largest-count channel search, a full scan of one channel per cycle
   reports the valid channel with the most queued beats, lowest index on a tie */
`timescale 1ns/1ps

module max_count_seeker #(
    parameter int num_ch = collect_cfg_pkg::NUM_CH,
    parameter int cnt_w  = collect_cfg_pkg::CNT_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [num_ch-1:0] valid,
    input  logic [cnt_w-1:0]  count [num_ch],
    seek_if.seeker            seek
);
    localparam int ch_w = (num_ch > 1) ? $clog2(num_ch) : 1;
    localparam logic [ch_w-1:0] last_ch = ch_w'(num_ch - 1);

    logic             busy;
    logic [ch_w-1:0]  idx;
    logic             found;
    logic             done_q;
    logic             empty_q;

    // best candidate so far
    logic [ch_w-1:0]  best_ch;
    logic [cnt_w-1:0] best_cnt;

    logic [ch_w-1:0]  cur;
    logic             take;
    logic             found_next;

    always_comb begin
        // scan always begins at channel 0, in the start cycle
        cur = seek.start ? '0 : idx;
        // strictly larger only, so an earlier channel keeps a tie
        take = valid[cur] && (seek.start || !found || count[cur] > best_cnt);
        // a new start forgets the previous result
        found_next = take || (found && !seek.start);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            idx     <= '0;
            found   <= 1'b0;
            done_q  <= 1'b0;
            empty_q <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            empty_q <= 1'b0;
            if (seek.start || busy) begin
                found <= found_next;
                if (cur == last_ch) begin
                    // last channel seen, report either way
                    busy    <= 1'b0;
                    done_q  <= found_next;
                    empty_q <= !found_next;
                end else begin
                    busy <= 1'b1;
                    idx  <= cur + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((seek.start || busy) && take) begin
            best_ch  <= cur;
            best_cnt <= count[cur];
        end
    end

    // best_ch only moves during a search, so it holds after done
    assign seek.done  = done_q;
    assign seek.empty = empty_q;
    assign seek.ch    = best_ch;

endmodule

// File: rtl/packet_mux.sv
/* combiner of the packet collector
   starts the selected seeker, locks the granted channel and fills the one-beat output slot */
`timescale 1ns/1ps

module packet_mux #(
    parameter int num_ch = collect_cfg_pkg::NUM_CH,
    parameter int data_w = collect_cfg_pkg::DATA_W
) (
    input  logic                        clk,
    input  logic                        rst,
    input  collect_ctrl_pkg::arb_mode_e mode,
    seek_if.combiner                    rr,
    seek_if.combiner                    mc,
    input  logic [data_w-1:0]           in_data [num_ch],
    input  logic [num_ch-1:0]           in_last,
    input  logic [num_ch-1:0]           in_valid,
    output logic [num_ch-1:0]           in_ready,
    output logic [data_w-1:0]           out_data,
    output logic                        out_last,
    output logic                        out_valid,
    input  logic                        out_ready
);
    localparam int ch_w = (num_ch > 1) ? $clog2(num_ch) : 1;

    collect_ctrl_pkg::mux_state_e state;
    collect_ctrl_pkg::arb_mode_e  mode_q;

    logic            rr_start;
    logic            mc_start;
    logic [ch_w-1:0] grant;

    // answer of whichever seeker was started
    logic            sel_done;
    logic            sel_empty;
    logic [ch_w-1:0] sel_ch;
    logic            accept;

    always_comb begin
        if (mode_q == collect_ctrl_pkg::ARB_MAX_COUNT) begin
            sel_done  = mc.done;
            sel_empty = mc.empty;
            sel_ch    = mc.ch;
        end else begin
            sel_done  = rr.done;
            sel_empty = rr.empty;
            sel_ch    = rr.ch;
        end
    end

    // ready only toward the locked channel and only into an empty slot
    always_comb begin
        in_ready = '0;
        if (state == collect_ctrl_pkg::MUX_LOCKED && !out_valid) begin
            in_ready[grant] = 1'b1;
        end
    end

    assign accept = in_ready[grant] && in_valid[grant];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= collect_ctrl_pkg::MUX_IDLE;
            mode_q   <= collect_ctrl_pkg::ARB_ROUND_ROBIN;
            rr_start <= 1'b0;
            mc_start <= 1'b0;
            grant    <= '0;
        end else begin
            rr_start <= 1'b0;
            mc_start <= 1'b0;
            case (state)
                collect_ctrl_pkg::MUX_IDLE: begin
                    // mode is only looked at here
                    mode_q   <= mode;
                    rr_start <= (mode == collect_ctrl_pkg::ARB_ROUND_ROBIN);
                    mc_start <= (mode == collect_ctrl_pkg::ARB_MAX_COUNT);
                    state    <= collect_ctrl_pkg::MUX_SEEK;
                end
                collect_ctrl_pkg::MUX_SEEK: begin
                    if (sel_done) begin
                        grant <= sel_ch;
                        state <= collect_ctrl_pkg::MUX_LOCKED;
                    end else if (sel_empty) begin
                        // nothing queued, try again
                        state <= collect_ctrl_pkg::MUX_IDLE;
                    end
                end
                collect_ctrl_pkg::MUX_LOCKED: begin
                    // lock held until the packet's last beat is taken
                    if (accept && in_last[grant]) begin
                        state <= collect_ctrl_pkg::MUX_IDLE;
                    end
                end
                default: begin
                    state <= collect_ctrl_pkg::MUX_IDLE;
                end
            endcase
        end
    end

    assign rr.start = rr_start;
    assign mc.start = mc_start;

    // output slot, full flag is out_valid itself
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_valid && out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // beat payload, only loaded into an empty slot
    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= in_data[grant];
            out_last <= in_last[grant];
        end
    end

endmodule

// File: rtl/packet_collector.sv
/* packet collector top, gathers num_ch input streams onto one output stream
   whole packets are granted by round robin or largest count first, chosen by mode */
`timescale 1ns/1ps

module packet_collector #(
    parameter int num_ch = collect_cfg_pkg::NUM_CH,
    parameter int data_w = collect_cfg_pkg::DATA_W,
    parameter int cnt_w  = collect_cfg_pkg::CNT_W
) (
    input  logic                        clk,
    input  logic                        rst,
    input  collect_ctrl_pkg::arb_mode_e mode,
    input  logic [data_w-1:0]           in_data [num_ch],
    input  logic [num_ch-1:0]           in_last,
    input  logic [num_ch-1:0]           in_valid,
    output logic [num_ch-1:0]           in_ready,
    input  logic [cnt_w-1:0]            in_count [num_ch],
    output logic [data_w-1:0]           out_data,
    output logic                        out_last,
    output logic                        out_valid,
    input  logic                        out_ready
);

    // one request path per seeker
    seek_if #(.num_ch(num_ch)) rr_seek ();
    seek_if #(.num_ch(num_ch)) mc_seek ();

    rr_seeker #(
        .num_ch (num_ch)
    ) u_rr_seeker (
        .clk   (clk),
        .rst   (rst),
        .valid (in_valid),
        .seek  (rr_seek.seeker)
    );

    // count hints only matter to this one
    max_count_seeker #(
        .num_ch (num_ch),
        .cnt_w  (cnt_w)
    ) u_max_count_seeker (
        .clk   (clk),
        .rst   (rst),
        .valid (in_valid),
        .count (in_count),
        .seek  (mc_seek.seeker)
    );

    packet_mux #(
        .num_ch (num_ch),
        .data_w (data_w)
    ) u_packet_mux (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .rr        (rr_seek.combiner),
        .mc        (mc_seek.combiner),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// File: test/tb_packet_collector.sv
/* loads one packet per channel for each test of the packet collector
   predicts the packet order for each mode and checks every output beat */
`timescale 1ns/1ps

module tb_packet_collector;
    localparam int num_ch = 16;
    localparam int data_w = 32;
    localparam int cnt_w  = 8;

    logic                        clk;
    logic                        rst;
    collect_ctrl_pkg::arb_mode_e mode;
    logic [data_w-1:0]           in_data [num_ch];
    logic [num_ch-1:0]           in_last;
    logic [num_ch-1:0]           in_valid;
    logic [num_ch-1:0]           in_ready;
    logic [cnt_w-1:0]            in_count [num_ch];
    logic [data_w-1:0]           out_data;
    logic                        out_last;
    logic                        out_valid;
    logic                        out_ready;

    integer seed = 32'h776b;
    int mismatches = 0;
    int failures = 0;
    int cycles = 0;
    int cycle_limit = 20;
    int rr_ptr = 0;
    int test_no = 0;
    bit back_pressure = 0;

    // loaded length and next beat of each channel
    int pkt_len [num_ch];
    int beat_idx [num_ch];

    // predicted output beats with the oldest first
    logic [data_w-1:0] exp_data [$];
    logic              exp_last [$];

    packet_collector #(
        .num_ch (num_ch),
        .data_w (data_w),
        .cnt_w  (cnt_w)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_count  (in_count),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // test number, channel and beat index packed into one beat
    function automatic logic [data_w-1:0] beat_word(int test, int ch, int beat);
        return {8'(test), 8'(ch), 8'(beat), 8'hc3};
    endfunction

    // expected arbiter picks the next packet among the channels still loaded
    function automatic int next_grant(logic [num_ch-1:0] loaded, int lens [num_ch],
                                      collect_ctrl_pkg::arb_mode_e m, int ptr);
        int best;
        int c;
        best = -1;
        for (int i = 0; i < num_ch; i++) begin
            if (m == collect_ctrl_pkg::ARB_ROUND_ROBIN) begin
                // first loaded channel counting up from the pointer
                c = (ptr + i) % num_ch;
                if (loaded[c] && best < 0) begin
                    best = c;
                end
            end else if (loaded[i] && (best < 0 || lens[i] > lens[best])) begin
                // only a strictly larger length wins so ties stay with the lower index
                best = i;
            end
        end
        return best;
    endfunction

    function automatic int beats_left();
        int n;
        n = 0;
        for (int c = 0; c < num_ch; c++) begin
            n += pkt_len[c] - beat_idx[c];
        end
        return n;
    endfunction

    // current beat and queued count of every channel onto the inputs
    task automatic present_all();
        for (int c = 0; c < num_ch; c++) begin
            in_valid[c] = beat_idx[c] < pkt_len[c];
            in_data[c]  = beat_word(test_no, c, beat_idx[c]);
            in_last[c]  = beat_idx[c] == pkt_len[c] - 1;
            in_count[c] = cnt_w'(pkt_len[c] - beat_idx[c]);
        end
    endtask

    // one packet per masked channel and the predicted beats into the queue
    // distinct gives up to six channels six different lengths
    task automatic load_test(logic [num_ch-1:0] mask, collect_ctrl_pkg::arb_mode_e m,
                             bit distinct);
        logic [num_ch-1:0] left;
        int ch;
        int k;
        int r;
        int beats;
        test_no++;
        mode = m;
        left = '0;
        k = 0;
        beats = 0;
        r = {$random(seed)} % 6;
        for (int c = 0; c < num_ch; c++) begin
            if (!mask[c] || (distinct && k == 6)) begin
                pkt_len[c] = 0;
            end else if (distinct) begin
                pkt_len[c] = 1 + (k + r) % 6;
                k++;
            end else begin
                pkt_len[c] = 1 + {$random(seed)} % 6;
            end
            beat_idx[c] = 0;
            left[c] = pkt_len[c] > 0;
            beats += pkt_len[c];
        end
        cycle_limit += (beats * 2 + $countones(left) * (num_ch + 4)) * 2;
        while (left != '0) begin
            ch = next_grant(left, pkt_len, m, rr_ptr);
            for (int b = 0; b < pkt_len[ch]; b++) begin
                exp_data.push_back(beat_word(test_no, ch, b));
                exp_last.push_back(b == pkt_len[ch] - 1);
            end
            left[ch] = 1'b0;
            // pointer carries over into the next test
            if (m == collect_ctrl_pkg::ARB_ROUND_ROBIN) begin
                rr_ptr = (ch + 1) % num_ch;
            end
        end
        present_all();
    endtask

    // one falling edge per cycle until every loaded beat was taken
    task automatic drain();
        int g;
        while (beats_left() != 0) begin
            // in_ready only moves on the rising edge, so this is the next accept
            g = -1;
            for (int c = 0; c < num_ch; c++) begin
                if (in_ready[c] && in_valid[c]) begin
                    g = c;
                end
            end
            @(negedge clk);
            out_ready = back_pressure ? (({$random(seed)} % 4) != 0) : 1'b1;
            if (g >= 0) begin
                beat_idx[g]++;
            end
            present_all();
        end
    endtask

    initial begin
        logic [num_ch-1:0] mask;
        rst = 1'b1;
        mode = collect_ctrl_pkg::ARB_ROUND_ROBIN;
        out_ready = 1'b1;
        for (int c = 0; c < num_ch; c++) begin
            pkt_len[c] = 0;
            beat_idx[c] = 0;
        end
        present_all();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        // first load lands before the first search
        load_test('1, collect_ctrl_pkg::ARB_ROUND_ROBIN, 1'b0);
        drain();
        load_test('1, collect_ctrl_pkg::ARB_MAX_COUNT, 1'b0);
        drain();
        load_test(16'(({$random(seed)}) | 32'h0101), collect_ctrl_pkg::ARB_MAX_COUNT, 1'b1);
        drain();
        // sparse sets resume the pointer past the previous winner
        repeat (3) begin
            mask = 16'($random(seed));
            load_test((mask == '0) ? 16'h0001 : mask, collect_ctrl_pkg::ARB_ROUND_ROBIN, 1'b0);
            drain();
        end
        back_pressure = 1'b1;
        mask = 16'($random(seed));
        load_test(mask | 16'h8000, collect_ctrl_pkg::ARB_ROUND_ROBIN, 1'b0);
        drain();
        load_test('1, collect_ctrl_pkg::ARB_MAX_COUNT, 1'b0);
        drain();
        // the last beat may still sit stalled in the slot
        back_pressure = 1'b0;
        out_ready = 1'b1;
        while (exp_data.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("mismatches %0d, other failures %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // output checker samples a quarter period after the falling edge
    initial begin
        logic [data_w-1:0] ed;
        logic              el;
        logic [data_w-1:0] held_data;
        logic              held_last;
        bit                stalled;
        stalled = 1'b0;
        forever begin
            @(negedge clk);
            #10;
            if (rst && (out_valid !== 1'b0 || in_ready !== '0)) begin
                failures++;
                $display("out_valid or in_ready high during reset");
            end
            if (in_valid == '0 && in_ready != '0) begin
                failures++;
                $display("in_ready high with no channel valid");
            end
            if (out_valid && in_ready != '0) begin
                failures++;
                $display("in_ready high while the output slot is full");
            end
            // a stalled beat has to stay put
            if (stalled && !out_valid) begin
                failures++;
                $display("out_valid dropped without out_ready");
            end
            if (stalled && out_data !== held_data) begin
                mismatches++;
                $display("MISMATCH out_data held %h now %h", held_data, out_data);
            end
            if (stalled && out_last !== held_last) begin
                mismatches++;
                $display("MISMATCH out_last held %h now %h", held_last, out_last);
            end
            if (out_valid && out_ready) begin
                if (exp_data.size() == 0) begin
                    failures++;
                    $display("output beat %h arrived with none expected", out_data);
                end else begin
                    ed = exp_data.pop_front();
                    el = exp_last.pop_front();
                    if (out_data !== ed) begin
                        mismatches++;
                        $display("MISMATCH out_data got %h expected %h", out_data, ed);
                    end
                    if (out_last !== el) begin
                        mismatches++;
                        $display("MISMATCH out_last got %h expected %h", out_last, el);
                    end
                end
            end
            stalled = out_valid && !out_ready;
            held_data = out_data;
            held_last = out_last;
        end
    end

    // cycle counter against a limit that grows with each loaded test
    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d beats never seen", cycles, exp_data.size());
        $display("Something failed");
        $finish;
    end

endmodule

// File: list.f
rtl/collect_cfg_pkg.sv
rtl/collect_ctrl_pkg.sv
rtl/seek_if.sv
rtl/rr_seeker.sv
rtl/max_count_seeker.sv
rtl/packet_mux.sv
rtl/packet_collector.sv
test/tb_packet_collector.sv

// File: run.sh
#!/bin/sh
# builds the packet collector testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_packet_collector \
    -f list.f -o sim_packet_collector
./obj_dir/sim_packet_collector | tee sim.log

if grep -q "Everything OK" sim.log; then
    exit 0
fi
exit 1
